//--- rf_subsystem.f
+incdir+.
rf_pkg.sv
rf_wb_unit.sv
rf_reg_file.sv
rf_operand_fetch.sv
rf_subsystem.sv
tb_rf_subsystem.sv

//--- Makefile
# Verilator build and run for the register file subsystem
# override on the command line, e.g. make run BANKED=1

VERILATOR ?= verilator
BANKED    ?= 0
TOP       ?= tb_rf_subsystem
FILELIST  ?= rf_subsystem.f
OBJ_DIR   ?= obj_dir_banked$(BANKED)
LOG       ?= sim_banked$(BANKED).log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := rf_params.svh rf_pkg.sv rf_wb_unit.sv rf_reg_file.sv rf_operand_fetch.sv \
        rf_subsystem.sv tb_rf_subsystem.sv
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GBANKED=$(BANKED) -Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED (BANKED=$(BANKED))"; exit 1; \
	fi

clean:
	rm -rf obj_dir_banked* sim_banked*.log

//--- tb_rf_subsystem.sv
`include "rf_params.svh"

module tb_rf_subsystem #(
    parameter int unsigned BANKED = 0
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int B2B_LEN = 60;
    // reset, x0, single, six pair cases, four forward cases, back to back
    localparam int TEST_CYCLES = 4 + 12 + 47 + 6 * 8 + 4 * 8 + B2B_LEN + 6;
    localparam int TOTAL_CYCLES = TEST_CYCLES + 100;

    logic clk;
    logic rst_n;
    logic wb_valid;
    rf_pkg::wb_cmd_t wb_cmd;
    logic rd_valid;
    rf_pkg::rd_req_t rd_req;
    logic op_valid;
    rf_pkg::operands_t op;

    // reference copy of the architectural registers
    rf_pkg::arch_width_t ref_rf [`RF_NUM];
    rf_pkg::operands_t exp_q [$];
    integer seed;
    int error_count;

    rf_subsystem #(
        .BANKED (BANKED)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb_cmd   (wb_cmd),
        .rd_valid (rd_valid),
        .rd_req   (rd_req),
        .op_valid (op_valid),
        .op       (op)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic rf_pkg::arch_width_t rand_word();
        return $random(seed);
    endfunction

    function automatic rf_pkg::arch_width_t ref_read(input rf_pkg::rf_addr_t a);
        if (a == `RF_X0_ZERO) begin
            return '0;
        end
        return ref_rf[a];
    endfunction

    // low word goes to rd and high word to rd+1 while x0 stays zero
    function automatic void ref_write(input rf_pkg::wb_cmd_t cmd);
        rf_pkg::rf_addr_t partner;
        partner = cmd.addr + 5'd1;
        if (cmd.addr != `RF_X0_ZERO) begin
            ref_rf[cmd.addr] = cmd.result[`ARCH_WIDTH-1:0];
        end
        if (cmd.pair && (partner != `RF_X0_ZERO)) begin
            ref_rf[partner] = cmd.result[2*`ARCH_WIDTH-1:`ARCH_WIDTH];
        end
    endfunction

    // drives one cycle of stimulus on the falling edge
    task automatic drive_cycle(input logic wv, input rf_pkg::wb_cmd_t cmd,
                               input logic rv, input rf_pkg::rd_req_t req);
        rf_pkg::operands_t exp_op;
        @(negedge clk);
        wb_valid = wv;
        wb_cmd = cmd;
        rd_valid = rv;
        rd_req = req;
        // a read sees only commands strobed in earlier cycles
        if (rv) begin
            exp_op.data_a = ref_read(req.addr_a);
            exp_op.data_b = ref_read(req.addr_b);
            exp_op.data_c = ref_read(req.addr_c);
            exp_q.push_back(exp_op);
        end
        if (wv) begin
            ref_write(cmd);
        end
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        drive_cycle(1'b0, '0, 1'b0, '0);
        while ((exp_q.size() != 0) && (n < 5)) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("op_valid did not arrive for %0d reads at time %0t", exp_q.size(), $time);
            error_count += exp_q.size();
            exp_q.delete();
        end
    endtask

    task automatic compare_word(input string port, input rf_pkg::arch_width_t got,
                                input rf_pkg::arch_width_t want);
        if (got !== want) begin
            $display("[ERROR] %0t: port %s returned %h, expected %h", $time, port, got, want);
            error_count++;
        end
    endtask

    // responses are sampled on the falling edge while op is stable
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && op_valid) begin
                if (exp_q.size() == 0) begin
                    $display("op_valid arrived without a read request at time %0t", $time);
                    error_count++;
                end else begin
                    rf_pkg::operands_t exp_op;
                    exp_op = exp_q.pop_front();
                    compare_word("a", op.data_a, exp_op.data_a);
                    compare_word("b", op.data_b, exp_op.data_b);
                    compare_word("c", op.data_c, exp_op.data_c);
                end
            end
        end
    end

    task automatic test_x0();
        rf_pkg::wb_cmd_t cmd;
        // no response before the first read
        repeat (4) begin
            @(negedge clk);
            if (op_valid !== 1'b0) begin
                $display("[ERROR] %0t: op_valid high before any read", $time);
                error_count++;
            end
        end
        cmd.addr = `RF_X0_ZERO;
        cmd.pair = 1'b0;
        cmd.result = {rand_word(), rand_word()};
        drive_cycle(1'b0, cmd, 1'b1, '0);
        drive_cycle(1'b1, cmd, 1'b1, '0);
        drive_cycle(1'b0, cmd, 1'b1, '0);
        drive_cycle(1'b0, cmd, 1'b1, '0);
        wait_responses();
    endtask

    task automatic test_single();
        rf_pkg::wb_cmd_t cmd;
        rf_pkg::rd_req_t req;
        cmd.pair = 1'b0;
        for (int r = 1; r < `RF_NUM; r++) begin
            cmd.addr = rf_pkg::rf_addr_t'(r);
            cmd.result = {rand_word(), rand_word()};
            drive_cycle(1'b1, cmd, 1'b0, '0);
        end
        drive_cycle(1'b0, cmd, 1'b0, '0);
        // three consecutive registers per read so every register is read back
        for (int r = 1; r < `RF_NUM; r += 3) begin
            req.addr_a = rf_pkg::rf_addr_t'(r);
            req.addr_b = rf_pkg::rf_addr_t'(r + 1);
            req.addr_c = rf_pkg::rf_addr_t'(r + 2);
            drive_cycle(1'b0, cmd, 1'b1, req);
        end
        wait_responses();
    endtask

    task automatic pair_case(input rf_pkg::rf_addr_t rd);
        rf_pkg::wb_cmd_t cmd;
        rf_pkg::rd_req_t req;
        cmd.addr = rd;
        cmd.pair = 1'b1;
        cmd.result = {rand_word(), rand_word()};
        drive_cycle(1'b1, cmd, 1'b0, '0);
        // let it land in storage before reading
        drive_cycle(1'b0, cmd, 1'b0, '0);
        req.addr_a = rd - 5'd1;
        req.addr_b = rd;
        req.addr_c = rd + 5'd1;
        drive_cycle(1'b0, cmd, 1'b1, req);
        req.addr_a = rd + 5'd2;
        drive_cycle(1'b0, cmd, 1'b1, req);
        wait_responses();
    endtask

    task automatic forward_case(input rf_pkg::rf_addr_t rd, input logic pair);
        rf_pkg::wb_cmd_t cmd;
        rf_pkg::rd_req_t req;
        cmd.addr = rd;
        cmd.pair = pair;
        cmd.result = {rand_word(), rand_word()};
        req.addr_a = rd;
        req.addr_b = rd + 5'd1;
        req.addr_c = rd - 5'd1;
        // same cycle as the command still returns the old contents
        drive_cycle(1'b1, cmd, 1'b1, req);
        drive_cycle(1'b0, cmd, 1'b1, req);
        drive_cycle(1'b0, cmd, 1'b1, req);
        wait_responses();
    endtask

    task automatic test_back_to_back();
        rf_pkg::wb_cmd_t cmd;
        rf_pkg::rd_req_t req;
        rf_pkg::arch_width_t word;
        rf_pkg::rf_addr_t last_addr;
        last_addr = 5'd1;
        for (int i = 0; i < B2B_LEN; i++) begin
            cmd.addr = rf_pkg::rf_addr_t'(rand_word());
            word = rand_word();
            cmd.pair = word[0] && (cmd.addr != `RF_X31_T6);
            cmd.result = {rand_word(), rand_word()};
            // aim two ports at the previous destination to hit the bypass
            req.addr_a = last_addr;
            req.addr_b = last_addr + 5'd1;
            req.addr_c = rf_pkg::rf_addr_t'(rand_word());
            drive_cycle(1'b1, cmd, 1'b1, req);
            last_addr = cmd.addr;
        end
        wait_responses();
    endtask

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, simulation stopped", TOTAL_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'h09657dba;
        error_count = 0;
        rst_n = 1'b0;
        wb_valid = 1'b0;
        wb_cmd = '0;
        rd_valid = 1'b0;
        rd_req = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_x0();
        test_single();
        pair_case(5'd1);
        pair_case(5'd2);
        pair_case(5'd7);
        pair_case(5'd14);
        pair_case(5'd23);
        pair_case(5'd30);
        forward_case(5'd4, 1'b1);
        forward_case(5'd9, 1'b1);
        forward_case(5'd17, 1'b0);
        forward_case(5'd30, 1'b1);
        test_back_to_back();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rf_subsystem.sv
`include "rf_params.svh"

module rf_subsystem #(
    parameter int unsigned BANKED = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic wb_valid,
    input  rf_pkg::wb_cmd_t wb_cmd,
    input  logic rd_valid,
    input  rf_pkg::rd_req_t rd_req,
    output logic op_valid,
    output rf_pkg::operands_t op
);

    // registered write, shared by storage and bypass
    rf_pkg::rf_wr_t wr;

    rf_pkg::rf_addr_t rf_addr_a;
    rf_pkg::rf_addr_t rf_addr_b;
    rf_pkg::rf_addr_t rf_addr_c;
    rf_pkg::arch_width_t rf_data_a;
    rf_pkg::arch_width_t rf_data_b;
    rf_pkg::arch_width_t rf_data_c;

    rf_wb_unit u_wb_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_valid (wb_valid),
        .wb_cmd   (wb_cmd),
        .wr       (wr)
    );

    rf_reg_file #(
        .BANKED (BANKED)
    ) u_reg_file (
        .clk    (clk),
        .wr     (wr),
        .addr_a (rf_addr_a),
        .addr_b (rf_addr_b),
        .addr_c (rf_addr_c),
        .data_a (rf_data_a),
        .data_b (rf_data_b),
        .data_c (rf_data_c)
    );

    rf_operand_fetch u_operand_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_req    (rd_req),
        .wr        (wr),
        .rf_addr_a (rf_addr_a),
        .rf_addr_b (rf_addr_b),
        .rf_addr_c (rf_addr_c),
        .rf_data_a (rf_data_a),
        .rf_data_b (rf_data_b),
        .rf_data_c (rf_data_c),
        .op_valid  (op_valid),
        .op        (op)
    );

endmodule

//--- rf_operand_fetch.sv
`include "rf_params.svh"

module rf_operand_fetch (
    input  logic clk,
    input  logic rst_n,
    input  logic rd_valid,
    input  rf_pkg::rd_req_t rd_req,
    input  rf_pkg::rf_wr_t wr,
    output rf_pkg::rf_addr_t rf_addr_a,
    output rf_pkg::rf_addr_t rf_addr_b,
    output rf_pkg::rf_addr_t rf_addr_c,
    input  rf_pkg::arch_width_t rf_data_a,
    input  rf_pkg::arch_width_t rf_data_b,
    input  rf_pkg::arch_width_t rf_data_c,
    output logic op_valid,
    output rf_pkg::operands_t op
);

    rf_pkg::operands_t op_next;

    // pick the pending write over the stored word, x0 never matches
    function automatic rf_pkg::arch_width_t bypass(
        input rf_pkg::rf_addr_t src,
        input rf_pkg::arch_width_t rf_word,
        input rf_pkg::rf_wr_t w
    );
        rf_pkg::arch_width_t word;
        word = rf_word;
        if (src != `RF_X0_ZERO) begin
            if (w.we.rdp && (src == rf_pkg::get_rdp(w.addr_d))) begin
                word = w.data_dp;
            end
            if (w.we.rd && (src == w.addr_d)) begin
                word = w.data_d;
            end
        end
        return word;
    endfunction

    // register file is read straight from the request
    assign rf_addr_a = rd_req.addr_a;
    assign rf_addr_b = rd_req.addr_b;
    assign rf_addr_c = rd_req.addr_c;

    assign op_next.data_a = bypass(rd_req.addr_a, rf_data_a, wr);
    assign op_next.data_b = bypass(rd_req.addr_b, rf_data_b, wr);
    assign op_next.data_c = bypass(rd_req.addr_c, rf_data_c, wr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            op <= op_next;
        end
    end

    // fixed latency of one cycle, in both directions
    a_op_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |=> op_valid
    ) else $error("op_valid missing one cycle after rd_valid");

    a_op_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid |-> $past(rd_valid)
    ) else $error("op_valid without a request");

endmodule

//--- rf_reg_file.sv
`include "rf_params.svh"

module rf_reg_file #(
    parameter int unsigned BANKED = 0
) (
    input  logic clk,
    input  rf_pkg::rf_wr_t wr,
    input  rf_pkg::rf_addr_t addr_a,
    input  rf_pkg::rf_addr_t addr_b,
    input  rf_pkg::rf_addr_t addr_c,
    output rf_pkg::arch_width_t data_a,
    output rf_pkg::arch_width_t data_b,
    output rf_pkg::arch_width_t data_c
);

    // index bits of a bank, register number without its lsb
    localparam int IDX_W = $clog2(`RF_NUM) - 1;

    rf_pkg::rf_addr_t addr_dp;
    logic rd_we;
    logic rdp_we;

    rf_pkg::rf_addr_t raddr [3];
    rf_pkg::arch_width_t rdata [3];

    assign addr_dp = rf_pkg::get_rdp(wr.addr_d);

    // x0 never written, pair at x31 wraps to x0 and is dropped here
    assign rd_we = wr.we.rd && (wr.addr_d != `RF_X0_ZERO);
    assign rdp_we = wr.we.rdp && (addr_dp != `RF_X0_ZERO);

    assign raddr[0] = addr_a;
    assign raddr[1] = addr_b;
    assign raddr[2] = addr_c;

    if (BANKED == 0) begin : gen_flat

        rf_pkg::arch_width_t rf [1:`RF_NUM-1];

        always_ff @(posedge clk) begin
            if (rd_we) begin
                rf[wr.addr_d] <= wr.data_d;
            end
            if (rdp_we) begin
                rf[addr_dp] <= wr.data_dp;
            end
        end

        always_comb begin
            for (int i = 0; i < 3; i++) begin
                if (raddr[i] == `RF_X0_ZERO) begin
                    rdata[i] = '0;
                end else begin
                    rdata[i] = rf[raddr[i]];
                end
            end
        end

    end else begin : gen_banked

        typedef logic [IDX_W-1:0] idx_t;

        // even bank holds x0, x2 .. x30 and odd bank x1, x3 .. x31
        rf_pkg::arch_width_t rf_even [0:`RF_NUM/2-1];
        rf_pkg::arch_width_t rf_odd [0:`RF_NUM/2-1];

        logic rd_odd;
        idx_t idx_d;
        idx_t idx_dp;

        assign rd_odd = wr.addr_d[0];
        assign idx_d = wr.addr_d[IDX_W:1];
        // for odd rd the partner sits in the next even slot
        assign idx_dp = idx_d + idx_t'(rd_odd);

        // even bank gets rd when rd is even, else the pair half
        always_ff @(posedge clk) begin
            if (rd_we && !rd_odd) begin
                rf_even[idx_d] <= wr.data_d;
            end else if (rdp_we && rd_odd) begin
                rf_even[idx_dp] <= wr.data_dp;
            end
        end

        // odd bank always uses idx_d, partner of an even rd is rd|1
        always_ff @(posedge clk) begin
            if (rd_we && rd_odd) begin
                rf_odd[idx_d] <= wr.data_d;
            end else if (rdp_we && !rd_odd) begin
                rf_odd[idx_d] <= wr.data_dp;
            end
        end

        always_comb begin
            for (int i = 0; i < 3; i++) begin
                if (raddr[i] == `RF_X0_ZERO) begin
                    rdata[i] = '0;
                end else if (raddr[i][0]) begin
                    rdata[i] = rf_odd[raddr[i][IDX_W:1]];
                end else begin
                    rdata[i] = rf_even[raddr[i][IDX_W:1]];
                end
            end
        end

    end

    assign data_a = rdata[0];
    assign data_b = rdata[1];
    assign data_c = rdata[2];

    // producer must never pair a write at x31
    a_no_pair_x31: assert property (
        @(posedge clk) wr.we.rdp |-> (wr.addr_d != `RF_X31_T6)
    ) else $error("paired write with rd=x31 is illegal");

endmodule

//--- rf_wb_unit.sv
`include "rf_params.svh"

module rf_wb_unit (
    input  logic clk,
    input  logic rst_n,
    input  logic wb_valid,
    input  rf_pkg::wb_cmd_t wb_cmd,
    output rf_pkg::rf_wr_t wr
);

    rf_pkg::rf_we_t we_q;
    rf_pkg::rf_addr_t addr_q;
    rf_pkg::arch_width_t data_q;
    rf_pkg::arch_width_t data_p_q;

    // enables live for one cycle per accepted command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= '0;
        end else if (wb_valid) begin
            we_q.rd <= 1'b1;
            we_q.rdp <= wb_cmd.pair;
        end else begin
            we_q <= '0;
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            addr_q <= wb_cmd.addr;
            data_q <= wb_cmd.result[`ARCH_WIDTH-1:0];
            // high word only matters for paired commands
            data_p_q <= wb_cmd.result[2*`ARCH_WIDTH-1:`ARCH_WIDTH];
        end
    end

    assign wr.we = we_q;
    assign wr.addr_d = addr_q;
    assign wr.data_d = data_q;
    assign wr.data_dp = data_p_q;

    // destination must be known whenever a command is strobed
    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_cmd.addr)
    ) else $error("writeback strobed with unknown rd");

endmodule

//--- rf_pkg.sv
`include "rf_params.svh"

package rf_pkg;

    // register number and register value
    typedef logic [$clog2(`RF_NUM)-1:0] rf_addr_t;
    typedef logic [`ARCH_WIDTH-1:0] arch_width_t;

    // write enables, rdp also writes rd+1
    typedef struct packed {
        logic rd;
        logic rdp;
    } rf_we_t;

    // writeback command from execute
    // low word of result goes to rd, high word to rd+1
    typedef struct packed {
        rf_addr_t addr;
        logic pair;
        logic [2*`ARCH_WIDTH-1:0] result;
    } wb_cmd_t;

    // write bundle seen by the register file and the fetch bypass
    typedef struct packed {
        rf_we_t we;
        rf_addr_t addr_d;
        arch_width_t data_d;
        arch_width_t data_dp;
    } rf_wr_t;

    // three source register numbers
    typedef struct packed {
        rf_addr_t addr_a;
        rf_addr_t addr_b;
        rf_addr_t addr_c;
    } rd_req_t;

    typedef struct packed {
        arch_width_t data_a;
        arch_width_t data_b;
        arch_width_t data_c;
    } operands_t;

    // pair partner of rd, x31 wraps to x0 and is thereby dropped
    function automatic rf_addr_t get_rdp(input rf_addr_t rd);
        return rd + rf_addr_t'(1);
    endfunction

endpackage

//--- rf_params.svh
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// architectural register count of the integer file
`define RF_NUM 32

// width of one register
`define ARCH_WIDTH 32

// register numbers with special handling
// x0 is hard-wired to zero
`define RF_X0_ZERO 5'd0
// x31 has no pair partner
`define RF_X31_T6 5'd31

`endif
